// File: dsm_config.svh
`ifndef DSM_CONFIG_SVH
`define DSM_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receiver build constants.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of a decimated output word.
`define DSM_WIDTH 12

// integrator and comb stages per channel.
`define DSM_STAGES 2

// input bits per decimated output.
`define DSM_OSR 16

// moving-average depth. The buffer index is two bits wide, so this cannot change.
`define DSM_AVG_TAPS 4

// a full-scale stream grows by OSR**STAGES, plus guard bits for the four-tap sum.
`define DSM_INT_WIDTH (`DSM_WIDTH + `DSM_STAGES * $clog2(`DSM_OSR) + 4)

// full scale at the defaults is 4 * 16**2 = 1024, which already fits.
`define DSM_OUT_SHIFT 0

`endif

// File: dsm_sample_pkg.sv
`default_nettype none

`include "dsm_config.svh"

package dsm_sample_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sample types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one decimated word, as it leaves a decimator or the combiner.
  typedef logic signed [`DSM_WIDTH-1:0] sample_t;

  // integrator, comb and moving-average arithmetic.
  typedef logic signed [`DSM_INT_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

// File: dsm_mode_pkg.sv
`default_nettype none

package dsm_mode_pkg;

  // selects what the combiner emits each decimation period.
  typedef enum logic [1:0] {
    mode_sum,
    mode_diff,
    mode_a,
    mode_b
  } combine_mode_t;

endpackage

`default_nettype wire

// File: cic_decimator.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsm_config.svh"

module cic_decimator (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    bit_in,
  output dsm_sample_pkg::sample_t sample,
  output logic                    sample_valid,
  output logic                    settled
);
  import dsm_sample_pkg::*;

  localparam int stages        = `DSM_STAGES;
  localparam int cnt_width     = $clog2(`DSM_OSR);
  localparam int settle_count  = `DSM_STAGES + 4;
  localparam int out_cnt_width = $clog2(settle_count + 1);

  acc_t in_val;
  acc_t integ    [stages];
  acc_t comb_src [stages];
  acc_t comb     [stages];
  acc_t comb_dly [stages];
  acc_t avg_buf  [4];
  acc_t avg_sum;
  acc_t avg_shifted;

  logic [1:0]               avg_idx;
  logic [cnt_width-1:0]     dec_cnt;
  logic [out_cnt_width-1:0] out_cnt;
  logic                     dec_tick;

  // a one is +1, a zero is -1.
  assign in_val   = bit_in ? acc_t'(1) : -acc_t'(1);
  assign dec_tick = (dec_cnt == cnt_width'(`DSM_OSR - 1));

  // the first comb stage differentiates the last integrator.
  always_comb begin
    comb_src[0] = integ[stages-1];
    for (int i = 1; i < stages; i++) begin
      comb_src[i] = comb[i-1];
    end
  end

  // sum of the buffer as it stands after this tick's write.
  assign avg_sum = avg_buf[0] + avg_buf[1] + avg_buf[2] + avg_buf[3]
                   - avg_buf[avg_idx] + comb[stages-1];
  assign avg_shifted = avg_sum >>> `DSM_OUT_SHIFT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decimation timing and settle tracking.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_cnt      <= '0;
      sample_valid <= 1'b0;
      avg_idx      <= '0;
      out_cnt      <= '0;
      settled      <= 1'b0;
    end else begin
      sample_valid <= dec_tick;
      if (dec_tick) begin
        dec_cnt <= '0;
        avg_idx <= avg_idx + 2'd1;
        if (!settled) begin
          out_cnt <= out_cnt + 1'b1;
        end
        // output number stages+4 is the first with a full history behind it.
        if (out_cnt == out_cnt_width'(settle_count - 1)) begin
          settled <= 1'b1;
        end
      end else begin
        dec_cnt <= dec_cnt + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // filter data path.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < stages; i++) begin
        integ[i]    <= '0;
        comb[i]     <= '0;
        comb_dly[i] <= '0;
      end
      for (int i = 0; i < 4; i++) begin
        avg_buf[i] <= '0;
      end
      sample <= '0;
    end else begin
      integ[0] <= integ[0] + in_val;
      for (int i = 1; i < stages; i++) begin
        integ[i] <= integ[i] + integ[i-1];
      end

      if (dec_tick) begin
        for (int i = 0; i < stages; i++) begin
          comb[i]     <= comb_src[i] - comb_dly[i];
          comb_dly[i] <= comb_src[i];
        end
        avg_buf[avg_idx] <= comb[stages-1];
        sample           <= avg_shifted[`DSM_WIDTH-1:0];
      end
    end
  end

  // the strobe marks one word per period and never stretches.
  assert property (@(posedge clk) disable iff (reset) sample_valid |=> !sample_valid)
    else $error("cic_decimator: sample_valid high on two consecutive cycles");

endmodule

`default_nettype wire

// File: channel_combiner.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsm_config.svh"

module channel_combiner (
  input  logic                        clk,
  input  logic                        reset,
  input  dsm_mode_pkg::combine_mode_t mode,
  input  dsm_sample_pkg::sample_t     sample_a,
  input  dsm_sample_pkg::sample_t     sample_b,
  input  logic                        valid_a,
  input  logic                        valid_b,
  input  logic                        settled_a,
  input  logic                        settled_b,
  output dsm_sample_pkg::sample_t     out_sample,
  output logic                        out_valid,
  output logic                        out_settled
);
  import dsm_sample_pkg::*;
  import dsm_mode_pkg::*;

  logic signed [`DSM_WIDTH:0] wide_sum;
  logic signed [`DSM_WIDTH:0] wide_diff;
  sample_t                    selected;

  // clamp a word one bit wider than a sample to the signed sample range.
  function automatic sample_t saturate(input logic signed [`DSM_WIDTH:0] value);
    if (value[`DSM_WIDTH] != value[`DSM_WIDTH-1]) begin
      saturate = value[`DSM_WIDTH] ? {1'b1, {(`DSM_WIDTH-1){1'b0}}}
                                   : {1'b0, {(`DSM_WIDTH-1){1'b1}}};
    end else begin
      saturate = value[`DSM_WIDTH-1:0];
    end
  endfunction

  assign wide_sum  = sample_a + sample_b;
  assign wide_diff = sample_a - sample_b;

  always_comb begin
    case (mode)
      mode_sum:  selected = saturate(wide_sum);
      mode_diff: selected = saturate(wide_diff);
      mode_a:    selected = sample_a;
      default:   selected = sample_b;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output register, loaded once per period.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_sample  <= '0;
      out_valid   <= 1'b0;
      out_settled <= 1'b0;
    end else begin
      out_valid <= valid_a;
      if (valid_a) begin
        out_sample  <= selected;
        out_settled <= settled_a & settled_b;
      end
    end
  end

  // both decimators leave reset together, so only channel a's strobe is used above.
  assert property (@(posedge clk) disable iff (reset) valid_a == valid_b)
    else $error("channel_combiner: decimator strobes are out of step");

  assert property (@(posedge clk) reset |-> !out_valid)
    else $error("channel_combiner: out_valid high during reset");

endmodule

`default_nettype wire

// File: dual_dsm_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module dual_dsm_receiver (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        bit_a,
  input  logic                        bit_b,
  input  dsm_mode_pkg::combine_mode_t mode,
  output dsm_sample_pkg::sample_t     out_sample,
  output logic                        out_valid,
  output logic                        out_settled
);
  import dsm_sample_pkg::*;

  sample_t sample_a;
  sample_t sample_b;
  logic    valid_a;
  logic    valid_b;
  logic    settled_a;
  logic    settled_b;

  cic_decimator inst_a (
    .clk          (clk),
    .reset        (reset),
    .bit_in       (bit_a),
    .sample       (sample_a),
    .sample_valid (valid_a),
    .settled      (settled_a)
  );

  cic_decimator inst_b (
    .clk          (clk),
    .reset        (reset),
    .bit_in       (bit_b),
    .sample       (sample_b),
    .sample_valid (valid_b),
    .settled      (settled_b)
  );

  // one registered word per decimation period, one cycle after the strobes.
  channel_combiner combiner (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .sample_a    (sample_a),
    .sample_b    (sample_b),
    .valid_a     (valid_a),
    .valid_b     (valid_b),
    .settled_a   (settled_a),
    .settled_b   (settled_b),
    .out_sample  (out_sample),
    .out_valid   (out_valid),
    .out_settled (out_settled)
  );

endmodule

`default_nettype wire

// File: tb_dual_dsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "dsm_config.svh"

module tb_dual_dsm;
  import dsm_sample_pkg::*;
  import dsm_mode_pkg::*;

  localparam int fs_periods     = 20;
  localparam int rand_periods   = 40;
  localparam int num_outputs    = fs_periods + rand_periods;
  localparam int total_bits     = (num_outputs + 2) * `DSM_OSR;
  localparam int timeout_cycles = total_bits + 20 * `DSM_OSR;
  localparam int settle_outputs = `DSM_STAGES + 4;
  localparam int full_scale     = (4 * `DSM_OSR ** `DSM_STAGES) >>> `DSM_OUT_SHIFT;

  logic          clk;
  logic          reset;
  logic          bit_a;
  logic          bit_b;
  combine_mode_t mode;
  sample_t       out_sample;
  logic          out_valid;
  logic          out_settled;

  // everything driven so far, indexed by the cycle after reset release.
  logic          bits_a [total_bits];
  logic          bits_b [total_bits];
  combine_mode_t modes  [total_bits];

  integer seed;
  int     active_edges = 0;
  int     errors       = 0;
  int     checks       = 0;

  dual_dsm_receiver dut (
    .clk         (clk),
    .reset       (reset),
    .bit_a       (bit_a),
    .bit_b       (bit_b),
    .mode        (mode),
    .out_sample  (out_sample),
    .out_valid   (out_valid),
    .out_settled (out_settled)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset) begin
      active_edges <= active_edges + 1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // replays one channel from reset up to its decimated output number n.
  function automatic sample_t channel_sample(input int ch, input int n);
    acc_t    integ    [`DSM_STAGES];
    acc_t    comb     [`DSM_STAGES];
    acc_t    comb_dly [`DSM_STAGES];
    acc_t    comb_src [`DSM_STAGES];
    acc_t    taps     [4];
    acc_t    step;
    acc_t    total;
    int      cnt;
    int      tap_idx;
    sample_t result;
    for (int i = 0; i < `DSM_STAGES; i++) begin
      integ[i]    = '0;
      comb[i]     = '0;
      comb_dly[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      taps[i] = '0;
    end
    cnt     = 0;
    tap_idx = 0;
    result  = '0;
    for (int e = 0; e < n * `DSM_OSR; e++) begin
      step = (ch == 0 ? bits_a[e] : bits_b[e]) ? acc_t'(1) : -acc_t'(1);
      if (cnt == `DSM_OSR - 1) begin
        // each comb stage sees the previous period's output of the stage before it.
        comb_src[0] = integ[`DSM_STAGES-1];
        for (int i = 1; i < `DSM_STAGES; i++) begin
          comb_src[i] = comb[i-1];
        end
        taps[tap_idx] = comb[`DSM_STAGES-1];
        for (int i = 0; i < `DSM_STAGES; i++) begin
          comb[i]     = comb_src[i] - comb_dly[i];
          comb_dly[i] = comb_src[i];
        end
        total   = (taps[0] + taps[1] + taps[2] + taps[3]) >>> `DSM_OUT_SHIFT;
        result  = total[`DSM_WIDTH-1:0];
        tap_idx = (tap_idx + 1) % 4;
        cnt     = 0;
      end else begin
        cnt++;
      end
      // the integrators move together, each from its neighbour's old value.
      for (int i = `DSM_STAGES - 1; i > 0; i--) begin
        integ[i] = integ[i] + integ[i-1];
      end
      integ[0] = integ[0] + step;
    end
    return result;
  endfunction

  function automatic sample_t combine_expected(input combine_mode_t m, input int a,
                                               input int b);
    int wide;
    int max_val;
    max_val = (1 << (`DSM_WIDTH - 1)) - 1;
    case (m)
      mode_sum:  wide = a + b;
      mode_diff: wide = a - b;
      mode_a:    wide = a;
      default:   wide = b;
    endcase
    if (wide > max_val) begin
      wide = max_val;
    end else if (wide < -max_val - 1) begin
      wide = -max_val - 1;
    end
    return wide[`DSM_WIDTH-1:0];
  endfunction

  // the combiner takes the mode that is on its input during the strobe cycle.
  function automatic sample_t expected_output(input int n);
    return combine_expected(modes[n * `DSM_OSR], channel_sample(0, n), channel_sample(1, n));
  endfunction

  task automatic check_value(input string name, input logic signed [31:0] actual,
                             input logic signed [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : drive_stimulus
    combine_mode_t next_mode;
    logic          next_a;
    logic          next_b;
    logic [31:0]   rand_word;
    seed      = 32'hc1d7_f8d7;
    next_mode = mode_sum;
    reset     <= 1'b1;
    bit_a     = 1'b0;
    bit_b     = 1'b0;
    mode      = mode_sum;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int k = 0; k < total_bits; k++) begin
      if (k < fs_periods * `DSM_OSR) begin
        // opposite full-scale streams while the mode steps once per period.
        next_a    = 1'b1;
        next_b    = 1'b0;
        next_mode = combine_mode_t'((k / `DSM_OSR) % 4);
      end else begin
        rand_word = $random(seed);
        next_a    = rand_word[0];
        next_b    = rand_word[1];
        if (rand_word[6:4] == 3'd0) begin
          next_mode = combine_mode_t'(rand_word[9:8]);
        end
      end
      bits_a[k] = next_a;
      bits_b[k] = next_b;
      modes[k]  = next_mode;
      bit_a <= next_a;
      bit_b <= next_b;
      mode  <= next_mode;
      @(posedge clk);
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not complete within %0d clock cycles", timeout_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output checking.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : compare_outputs
    int waited;
    bit lost;
    lost = 1'b0;
    @(negedge clk);
    while (reset) begin
      check_value("out_valid", out_valid, 0);
      check_value("out_settled", out_settled, 0);
      check_value("out_sample", out_sample, 0);
      @(negedge clk);
    end
    for (int n = 1; n <= num_outputs && !lost; n++) begin
      @(negedge clk);
      waited = 1;
      while (!out_valid && waited < `DSM_OSR + 2) begin
        @(negedge clk);
        waited++;
      end
      if (!out_valid) begin
        $display("output %0d is missing: out_valid did not rise within %0d cycles",
                 n, `DSM_OSR + 2);
        errors++;
        lost = 1'b1;
      end else begin
        check_value("out_valid cycle", active_edges, n * `DSM_OSR + 1);
        check_value("out_settled", out_settled, n >= settle_outputs);
        check_value("out_sample", out_sample, expected_output(n));
        // well after the filter history has flushed, full scale gives fixed words.
        if (n >= 2 * settle_outputs && n <= fs_periods) begin
          check_value("out_sample", out_sample,
                      combine_expected(modes[n * `DSM_OSR], full_scale, -full_scale));
        end
      end
    end
    repeat (2) @(negedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
dsm_sample_pkg.sv
dsm_mode_pkg.sv
cic_decimator.sv
channel_combiner.sv
dual_dsm_receiver.sv
tb_dual_dsm.sv

// File: Bender.yml
package:
  name: dual_dsm_receiver

export_include_dirs:
  - .

sources:
  - files:
      - dsm_sample_pkg.sv
      - dsm_mode_pkg.sv
      - cic_decimator.sv
      - channel_combiner.sv
      - dual_dsm_receiver.sv
  - target: test
    files:
      - tb_dual_dsm.sv
